// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // one bus request as seen by every target
  typedef struct packed {
    // byte address, low two bits ignored
    logic [31:0] address;
    logic [31:0] writedata;
    logic [3:0]  be;
    logic        write;
  } bus_req_t;

  // read response, valid travels beside it
  typedef struct packed {
    logic [31:0] readdata;
  } bus_rsp_t;

  typedef enum logic {
    master_cpu = 1'b0,
    master_vga = 1'b1
  } master_t;

endpackage

`default_nettype wire

// File: src/map_pkg.sv
`default_nettype none

package map_pkg;

  // bit position of each target in the chip select
  typedef enum logic [1:0] {
    region_ram0 = 2'd0,
    region_ram1 = 2'd1,
    region_cfg  = 2'd2
  } region_t;

  localparam int unsigned num_regions = 3;

  localparam logic [31:0] ram0_base = 32'h0000_0000;
  localparam logic [31:0] ram1_base = 32'hC000_0000;
  localparam logic [31:0] cfg_base  = 32'h3000_0000;
  // boot vector area, mirror of ram0 in boot mode
  localparam logic [31:0] boot_base = 32'hFFFF_0000;

  // all regions are 64 KiB and aligned to their size
  localparam int unsigned region_size = 32'h0001_0000;
  localparam int unsigned region_lsb  = $clog2(region_size);

  typedef enum logic {
    map_normal = 1'b0,
    map_boot   = 1'b1
  } map_mode_t;

endpackage

`default_nettype wire

// File: src/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  wire bus_pkg::bus_req_t cpu_req,
  input  wire logic              cpu_valid,
  input  wire bus_pkg::bus_req_t vga_req,
  input  wire logic              vga_valid,
  output logic                   cpu_ready,
  output logic                   vga_ready,
  output bus_pkg::bus_req_t      grant_req,
  output logic                   grant_valid,
  output bus_pkg::master_t       grant_master
);

  import bus_pkg::*;

  // display fetch always wins
  assign vga_ready = vga_valid;
  assign cpu_ready = cpu_valid & ~vga_valid;

  assign grant_valid = vga_valid | cpu_valid;

  always_comb begin
    if (vga_valid) begin
      grant_req       = vga_req;
      // fetch port is read only
      grant_req.write = 1'b0;
      grant_master    = master_vga;
    end else begin
      grant_req    = cpu_req;
      grant_master = master_cpu;
    end
  end

endmodule

`default_nettype wire

// File: src/addr_decoder.sv
`default_nettype none

module addr_decoder (
  input  wire logic                         clock_50,
  input  wire logic                         arst_n,
  input  wire bus_pkg::bus_req_t            grant_req,
  input  wire logic                         grant_valid,
  input  wire bus_pkg::master_t             grant_master,
  input  wire map_pkg::map_mode_t           map_mode,
  input  wire logic [31:0]                  ram0_rdata,
  input  wire logic [31:0]                  ram1_rdata,
  input  wire logic [31:0]                  cfg_rdata,
  output logic [map_pkg::num_regions-1:0]   chip_select,
  output bus_pkg::bus_req_t                 target_req,
  output logic                              unmapped_hit,
  output bus_pkg::bus_rsp_t                 cpu_rsp,
  output logic                              cpu_rsp_valid,
  output bus_pkg::bus_rsp_t                 vga_rsp,
  output logic                              vga_rsp_valid
);

  import bus_pkg::*;
  import map_pkg::*;

  logic [31-region_lsb:0] page;
  logic                   hit_ram0;
  logic                   hit_ram1;
  logic                   hit_cfg;
  logic                   hit_boot;
  logic [num_regions-1:0] sel;
  logic                   rd_accept;
  logic                   rd_valid_q;
  master_t                rd_master_q;
  logic [num_regions-1:0] rd_sel_q;
  logic [31:0]            rd_data;

  assign page     = grant_req.address[31:region_lsb];
  assign hit_ram0 = page == ram0_base[31:region_lsb];
  assign hit_ram1 = page == ram1_base[31:region_lsb];
  assign hit_cfg  = page == cfg_base[31:region_lsb];
  assign hit_boot = (map_mode == map_boot) && (page == boot_base[31:region_lsb]);

  always_comb begin
    sel              = '0;
    sel[region_ram0] = hit_ram0 | hit_boot;
    sel[region_ram1] = hit_ram1;
    sel[region_cfg]  = hit_cfg;
  end

  assign chip_select  = grant_valid ? sel : '0;
  assign unmapped_hit = grant_valid && (sel == '0);

  // mirror hits are moved into ram0 space
  always_comb begin
    target_req = grant_req;
    if (hit_boot) begin
      target_req.address[31:region_lsb] = ram0_base[31:region_lsb];
    end
  end

  assign rd_accept = grant_valid & ~grant_req.write;

  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid_q  <= 1'b0;
      rd_master_q <= master_cpu;
      rd_sel_q    <= '0;
    end else begin
      rd_valid_q <= rd_accept;
      if (rd_accept) begin
        rd_master_q <= grant_master;
        rd_sel_q    <= sel;
      end
    end
  end

  // no region selected gives zero
  always_comb begin
    rd_data = '0;
    if (rd_sel_q[region_ram0]) begin
      rd_data = ram0_rdata;
    end else if (rd_sel_q[region_ram1]) begin
      rd_data = ram1_rdata;
    end else if (rd_sel_q[region_cfg]) begin
      rd_data = cfg_rdata;
    end
  end

  assign cpu_rsp.readdata = rd_data;
  assign vga_rsp.readdata = rd_data;
  assign cpu_rsp_valid    = rd_valid_q && (rd_master_q == master_cpu);
  assign vga_rsp_valid    = rd_valid_q && (rd_master_q == master_vga);

endmodule

`default_nettype wire

// File: src/map_config.sv
`default_nettype none

module map_config #(
  parameter map_pkg::map_mode_t boot_map = map_pkg::map_normal
) (
  input  wire logic              clock_50,
  input  wire logic              arst_n,
  input  wire logic              select,
  input  wire bus_pkg::bus_req_t req,
  input  wire logic              unmapped_hit,
  output logic [31:0]            rdata,
  output map_pkg::map_mode_t     map_mode
);

  import map_pkg::*;

  logic        wr;
  logic        rd;
  map_mode_t   mode_q;
  logic [15:0] unmapped_cnt;

  assign wr = select & req.write;
  assign rd = select & ~req.write;

  // offset 0 holds the mode, offset 4 the counter
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      mode_q <= boot_map;
    end else if (wr && !req.address[2] && req.be[0]) begin
      mode_q <= map_mode_t'(req.writedata[0]);
    end
  end

  // clear beats a same cycle hit, count saturates
  always_ff @(posedge clock_50 or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_cnt <= '0;
    end else if (wr && req.address[2]) begin
      unmapped_cnt <= '0;
    end else if (unmapped_hit && (unmapped_cnt != '1)) begin
      unmapped_cnt <= unmapped_cnt + 16'd1;
    end
  end

  always_ff @(posedge clock_50) begin
    if (rd) begin
      if (req.address[2]) begin
        rdata <= {16'h0000, unmapped_cnt};
      end else begin
        rdata <= {31'd0, mode_q};
      end
    end
  end

  assign map_mode = mode_q;

endmodule

`default_nettype wire

// File: src/scratch_ram.sv
`default_nettype none

module scratch_ram #(
  parameter int unsigned words = 1024
) (
  input  wire logic              clock_50,
  input  wire logic              select,
  input  wire bus_pkg::bus_req_t req,
  output logic [31:0]            rdata
);

  localparam int unsigned aw = $clog2(words);

  logic [31:0]   mem [words];
  logic [aw-1:0] idx;

  // word index wraps at the memory depth
  assign idx = req.address[aw+1:2];

  always_ff @(posedge clock_50) begin
    if (select && req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          mem[idx][8*b +: 8] <= req.writedata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (select && !req.write) begin
      rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: src/soc_bus.sv
`default_nettype none

module soc_bus #(
  parameter int unsigned        ram0_words = 4096,
  parameter int unsigned        ram1_words = 1024,
  parameter map_pkg::map_mode_t boot_map   = map_pkg::map_normal
) (
  input  wire logic              clock_50,
  input  wire logic              arst_n,
  input  wire bus_pkg::bus_req_t cpu_req,
  input  wire logic              cpu_valid,
  input  wire bus_pkg::bus_req_t vga_req,
  input  wire logic              vga_valid,
  output logic                   cpu_ready,
  output bus_pkg::bus_rsp_t      cpu_rsp,
  output logic                   cpu_rsp_valid,
  output logic                   vga_ready,
  output bus_pkg::bus_rsp_t      vga_rsp,
  output logic                   vga_rsp_valid
);

  import bus_pkg::*;
  import map_pkg::*;

  bus_req_t               grant_req;
  logic                   grant_valid;
  master_t                grant_master;
  bus_req_t               target_req;
  logic [num_regions-1:0] chip_select;
  logic                   unmapped_hit;
  map_mode_t              map_mode;
  logic [31:0]            ram0_rdata;
  logic [31:0]            ram1_rdata;
  logic [31:0]            cfg_rdata;

  bus_arbiter arb0 (
    .cpu_req(cpu_req), .cpu_valid(cpu_valid),
    .vga_req(vga_req), .vga_valid(vga_valid),
    .cpu_ready(cpu_ready), .vga_ready(vga_ready),
    .grant_req(grant_req), .grant_valid(grant_valid), .grant_master(grant_master)
  );

  addr_decoder dec0 (
    .clock_50(clock_50), .arst_n(arst_n),
    .grant_req(grant_req), .grant_valid(grant_valid), .grant_master(grant_master),
    .map_mode(map_mode),
    .ram0_rdata(ram0_rdata), .ram1_rdata(ram1_rdata), .cfg_rdata(cfg_rdata),
    .chip_select(chip_select), .target_req(target_req), .unmapped_hit(unmapped_hit),
    .cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid),
    .vga_rsp(vga_rsp), .vga_rsp_valid(vga_rsp_valid)
  );

  map_config #(.boot_map(boot_map)) cfg0 (
    .clock_50(clock_50), .arst_n(arst_n),
    .select(chip_select[region_cfg]), .req(target_req),
    .unmapped_hit(unmapped_hit),
    .rdata(cfg_rdata), .map_mode(map_mode)
  );

  // scratch memory
  scratch_ram #(.words(ram0_words)) ram0 (
    .clock_50(clock_50), .select(chip_select[region_ram0]),
    .req(target_req), .rdata(ram0_rdata)
  );

  // video memory
  scratch_ram #(.words(ram1_words)) ram1 (
    .clock_50(clock_50), .select(chip_select[region_ram1]),
    .req(target_req), .rdata(ram1_rdata)
  );

endmodule

`default_nettype wire

// File: tb/tb_soc_bus.sv
`default_nettype none

module tb_soc_bus;

  import bus_pkg::*;
  import map_pkg::*;

  localparam int unsigned ram0_words = 256;
  localparam int unsigned ram1_words = 64;
  localparam int unsigned max_cycles = 2000;
  localparam logic [31:0] cfg_addr   = 32'h3000_0000;
  localparam logic [31:0] boot_addr  = 32'hFFFF_0000;

  logic     clock_50;
  logic     arst_n;
  bus_req_t cpu_req;
  logic     cpu_valid;
  bus_req_t vga_req;
  logic     vga_valid;
  logic     cpu_ready;
  bus_rsp_t cpu_rsp;
  logic     cpu_rsp_valid;
  logic     vga_ready;
  bus_rsp_t vga_rsp;
  logic     vga_rsp_valid;

  // reference model of both memories and the bus-map registers
  logic [31:0] ram0_model [ram0_words];
  logic [31:0] ram1_model [ram1_words];
  map_mode_t   mode_model;
  logic [15:0] count_model;

  integer      seed   = 32'hb668_b5aa;
  int unsigned cycles = 0;

  soc_bus #(
    .ram0_words(ram0_words), .ram1_words(ram1_words), .boot_map(map_normal)
  ) UUT (
    .clock_50(clock_50), .arst_n(arst_n),
    .cpu_req(cpu_req), .cpu_valid(cpu_valid), .vga_req(vga_req), .vga_valid(vga_valid),
    .cpu_ready(cpu_ready), .cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid),
    .vga_ready(vga_ready), .vga_rsp(vga_rsp), .vga_rsp_valid(vga_rsp_valid)
  );

  initial begin
    clock_50 = 1'b0;
    forever #50 clock_50 = ~clock_50;
  end

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clock_50) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d clock cycles", max_cycles);
      abort_run();
    end
  end

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got.readdata, exp.readdata);
      abort_run();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic bus_req_t make_req(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] be, input logic write);
    bus_req_t r;
    r.address   = addr;
    r.writedata = data;
    r.be        = be;
    r.write     = write;
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input bus_req_t r);
    logic [31:0] v;
    v = old;
    for (int b = 0; b < 4; b++) begin
      if (r.be[b]) begin
        v[8*b +: 8] = r.writedata[8*b +: 8];
      end
    end
    return v;
  endfunction

  // applies one accepted access to the model
  // rd returns the expected read data
  task automatic model_access(input bus_req_t r, output logic [31:0] rd);
    logic [15:0] page;
    int unsigned w;
    page = r.address[31:16];
    w    = r.address[31:2];
    rd   = '0;
    if (page == 16'h0000 || (mode_model == map_boot && page == 16'hFFFF)) begin
      w = w % ram0_words;
      if (r.write) begin
        ram0_model[w] = merge_bytes(ram0_model[w], r);
      end else begin
        rd = ram0_model[w];
      end
    end else if (page == 16'hC000) begin
      w = w % ram1_words;
      if (r.write) begin
        ram1_model[w] = merge_bytes(ram1_model[w], r);
      end else begin
        rd = ram1_model[w];
      end
    end else if (page == 16'h3000) begin
      if (r.write && r.address[2]) begin
        count_model = '0;
      end else if (r.write && r.be[0]) begin
        mode_model = map_mode_t'(r.writedata[0]);
      end else if (!r.write) begin
        rd = r.address[2] ? {16'h0000, count_model} : {31'd0, mode_model};
      end
    end else if (count_model != 16'hFFFF) begin
      count_model = count_model + 16'd1;
    end
  endtask

  // readies sampled at the rising edge
  // responses checked at the next falling edge
  task automatic step(output logic cpu_rdy, output logic vga_rdy);
    bus_req_t    r;
    logic [31:0] rd;
    logic        exp_cpu_v;
    logic        exp_vga_v;
    bus_rsp_t    exp_rsp;
    @(posedge clock_50);
    cpu_rdy   = cpu_ready;
    vga_rdy   = vga_ready;
    exp_cpu_v = 1'b0;
    exp_vga_v = 1'b0;
    rd        = '0;
    if (vga_valid) begin
      check_ready("cpu_ready", cpu_rdy, 1'b0);
    end
    if (vga_valid && vga_rdy) begin
      r         = vga_req;
      r.write   = 1'b0;
      exp_vga_v = 1'b1;
      model_access(r, rd);
    end else if (cpu_valid && cpu_rdy) begin
      exp_cpu_v = !cpu_req.write;
      model_access(cpu_req, rd);
    end
    exp_rsp.readdata = rd;
    @(negedge clock_50);
    check_valid("cpu_rsp_valid", cpu_rsp_valid, exp_cpu_v);
    check_valid("vga_rsp_valid", vga_rsp_valid, exp_vga_v);
    if (exp_cpu_v) begin
      check_rsp("cpu_rsp", cpu_rsp, exp_rsp);
    end
    if (exp_vga_v) begin
      check_rsp("vga_rsp", vga_rsp, exp_rsp);
    end
  endtask

  task automatic cpu_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, input logic write);
    logic cr;
    logic vr;
    cpu_req   = make_req(addr, data, be, write);
    cpu_valid = 1'b1;
    step(cr, vr);
    while (!cr) begin
      step(cr, vr);
    end
    cpu_valid = 1'b0;
  endtask

  task automatic vga_read(input logic [31:0] addr);
    logic cr;
    logic vr;
    vga_req   = make_req(addr, 32'h0, 4'hF, 1'b0);
    vga_valid = 1'b1;
    step(cr, vr);
    while (!vr) begin
      step(cr, vr);
    end
    vga_valid = 1'b0;
  endtask

  task automatic byte_enable_rw();
    for (int i = 0; i < 8; i++) begin
      cpu_access(32'h40 + 4 * i, $random(seed), 4'(3 * i + 1), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      cpu_access(32'h40 + 4 * i, 32'h0, 4'hF, 1'b0);
    end
  endtask

  task automatic display_reads();
    for (int i = 0; i < 8; i++) begin
      cpu_access(32'hC000_0000 + 4 * i, $random(seed), 4'hF, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      vga_read(32'hC000_0000 + 4 * i);
    end
    // one past the depth wraps to word 0
    vga_read(32'hC000_0100);
  endtask

  task automatic both_masters_valid();
    logic cr;
    logic vr;
    // stray write bit on the fetch port must still give a read
    vga_req   = make_req(32'hC000_0004, 32'hA5A5_5A5A, 4'hF, 1'b1);
    cpu_req   = make_req(32'h0000_0044, 32'h0, 4'hF, 1'b0);
    vga_valid = 1'b1;
    cpu_valid = 1'b1;
    step(cr, vr);
    check_ready("vga_ready", vr, 1'b1);
    vga_valid = 1'b0;
    step(cr, vr);
    check_ready("cpu_ready", cr, 1'b1);
    cpu_valid = 1'b0;
  endtask

  task automatic unmapped_counter();
    cpu_access(cfg_addr + 4, 32'h0, 4'hF, 1'b0);
    cpu_access(32'h5000_0000, 32'h0, 4'hF, 1'b0);
    cpu_access(cfg_addr + 4, 32'h0, 4'hF, 1'b0);
    cpu_access(cfg_addr + 4, 32'h0, 4'hF, 1'b1);
    cpu_access(cfg_addr + 4, 32'h0, 4'hF, 1'b0);
  endtask

  task automatic boot_mirror();
    cpu_access(boot_addr, 32'h0, 4'hF, 1'b0);
    cpu_access(cfg_addr, 32'h1, 4'h1, 1'b1);
    cpu_access(cfg_addr, 32'h0, 4'hF, 1'b0);
    cpu_access(boot_addr, 32'h0, 4'hF, 1'b0);
    cpu_access(boot_addr + 8, $random(seed), 4'hF, 1'b1);
    cpu_access(32'h0000_0008, 32'h0, 4'hF, 1'b0);
    cpu_access(cfg_addr, 32'h0, 4'h1, 1'b1);
  endtask

  task automatic back_to_back_reads();
    logic        cr;
    logic        vr;
    logic [31:0] addr;
    for (int i = 0; i < 30; i++) begin
      addr      = $random(seed) & 32'h0000_03FC;
      cpu_req   = make_req(addr, 32'h0, 4'hF, 1'b0);
      cpu_valid = 1'b1;
      step(cr, vr);
      check_ready("cpu_ready", cr, 1'b1);
    end
    cpu_valid = 1'b0;
  endtask

  initial begin
    arst_n      = 1'b0;
    cpu_valid   = 1'b0;
    vga_valid   = 1'b0;
    cpu_req     = '0;
    vga_req     = '0;
    mode_model  = map_normal;
    count_model = '0;
    repeat (2) @(posedge clock_50);
    @(negedge clock_50);
    arst_n = 1'b1;
    check_valid("cpu_rsp_valid", cpu_rsp_valid, 1'b0);
    check_valid("vga_rsp_valid", vga_rsp_valid, 1'b0);
    // fill ram0 so random reads see defined data
    for (int i = 0; i < ram0_words; i++) begin
      cpu_access(4 * i, (4 * i * 32'h9E37_79B9) ^ 32'h5A5A_0F0F, 4'hF, 1'b1);
    end
    byte_enable_rw();
    display_reads();
    both_masters_valid();
    unmapped_counter();
    boot_mirror();
    back_to_back_reads();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/bus_pkg.sv
src/map_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/map_config.sv
src/scratch_ram.sv
src/soc_bus.sv
tb/tb_soc_bus.sv
